//--- logic/engine_types_pkg.sv
// Widths and vector types shared by the memory engine; referenced by scoped name only
package engine_types_pkg;

  // --------------------------------------
  // Bus widths
  // --------------------------------------
  localparam int ADDR_W = 32;         // Byte address width
  localparam int DATA_W = 32;         // One memory word
  localparam int STRB_W = DATA_W / 8; // One enable bit per byte
  localparam int ID_W   = 8;          // Request tag width

  // --------------------------------------
  // Vector types
  // --------------------------------------
  // Byte address, also used for the descriptor base and request offsets
  typedef logic [ADDR_W-1:0] addr_t;

  // Data word on both write and read paths
  typedef logic [DATA_W-1:0] data_t;

  // Byte-enable mask, bit i covers byte i of data_t
  typedef logic [STRB_W-1:0] strb_t;

  // Tag of a request, echoed back unchanged with its response
  typedef logic [ID_W-1:0] req_id_t;

endpackage : engine_types_pkg

//--- logic/engine_cmd_pkg.sv
// Memory command codes and their read/write classification for the memory engine
package engine_cmd_pkg;

  // 3-bit command code carried with every request
  typedef logic [2:0] cmd_t;

  // --------------------------------------
  // Command codes
  // --------------------------------------
  localparam cmd_t CMD_MEM_READ     = 3'd1; // Plain word read
  localparam cmd_t CMD_MEM_WRITE    = 3'd2; // Plain word write
  localparam cmd_t CMD_STREAM_READ  = 3'd3; // Streaming read
  localparam cmd_t CMD_STREAM_WRITE = 3'd4; // Streaming write
  localparam cmd_t CMD_CACHE_FLUSH  = 3'd5; // Issued like a read, no bytes written

  // True only for codes that modify memory
  // Everything else goes out as a read with no strobes
  function automatic logic is_write(cmd_t cmd);
    return (cmd == CMD_MEM_WRITE) || (cmd == CMD_STREAM_WRITE);
  endfunction

endpackage : engine_cmd_pkg

//--- logic/engine_if.sv
// Internal stage-to-stage interfaces of the memory engine, connected in the top level
`timescale 1ns/1ps

// Request queue head, offered by the decode stage to the execute stage
interface issue_if;
  logic                      valid; // Queue head exists
  engine_types_pkg::addr_t   addr;  // Mapped byte address
  engine_types_pkg::data_t   wdata; // Write payload
  engine_types_pkg::strb_t   wstrb; // Raw strobes, masked later for non-writes
  engine_cmd_pkg::cmd_t      cmd;
  engine_types_pkg::req_id_t id;
  logic                      pop;   // Head taken, only while valid

  modport decode (
    output valid, addr, wdata, wstrb, cmd, id,
    input  pop
  );

  modport execute (
    input  valid, addr, wdata, wstrb, cmd, id,
    output pop
  );
endinterface : issue_if

// Identity of granted commands, handed from execute to the response stage
interface meta_if;
  logic                      push;      // One per grant
  engine_cmd_pkg::cmd_t      cmd;
  engine_types_pkg::req_id_t id;
  logic                      prog_full; // Response queue at or above threshold
  logic                      empty;     // No response outstanding

  modport execute (
    output push, cmd, id,
    input  prog_full
  );

  modport result (
    input  push, cmd, id,
    output prog_full, empty
  );
endinterface : meta_if

//--- logic/sync_fifo.sv
// Single-clock first-word-fall-through FIFO; instantiated for the request and response queues
`timescale 1ns/1ps

module sync_fifo #(
  parameter int WIDTH  = 32,
  parameter int DEPTH  = 16, // Power of two
  parameter int THRESH = 8   // Fill level that raises prog_full_o
) (
  input  logic             ap_clk_i,
  input  logic             areset_control_i,
  input  logic             wr_en_i,
  input  logic [WIDTH-1:0] din_i,
  input  logic             rd_en_i,
  output logic [WIDTH-1:0] dout_o,      // Head word, valid while not empty
  output logic             empty_o,
  output logic             full_o,
  output logic             prog_full_o
);

  localparam int AW = $clog2(DEPTH); // Pointer width
  localparam int CW = AW + 1;        // Count reaches DEPTH

  logic [WIDTH-1:0] mem [DEPTH]; // Storage, no reset
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [CW-1:0]    count;
  logic             do_wr;
  logic             do_rd;

  // Requests against a full or empty queue are ignored
  assign do_wr = wr_en_i & ~full_o;
  assign do_rd = rd_en_i & ~empty_o;

  // --------------------------------------
  // Pointers and fill count
  // --------------------------------------
  always_ff @(posedge ap_clk_i) begin
    if (areset_control_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1; // Wraps at DEPTH
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;     // Idle or push and pop together
      endcase
    end
  end

  // Write port
  always_ff @(posedge ap_clk_i) begin
    if (do_wr) begin
      mem[wr_ptr] <= din_i;
    end
  end

  // --------------------------------------
  // Status and fall-through read
  // --------------------------------------
  assign dout_o      = mem[rd_ptr];           // Head shows without a read
  assign empty_o     = (count == '0);
  assign full_o      = (count == CW'(DEPTH));
  assign prog_full_o = (count >= CW'(THRESH));

endmodule : sync_fifo

//--- logic/request_decode.sv
// Decode stage: latches the descriptor, maps requests to commands and queues them for issue
`timescale 1ns/1ps

module request_decode #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                      ap_clk_i,
  input  logic                      areset_control_i,
  input  logic                      desc_valid_i,
  input  engine_types_pkg::addr_t   desc_base_i,
  input  logic                      request_valid_i,
  input  engine_cmd_pkg::cmd_t      request_cmd_i,
  input  engine_types_pkg::req_id_t request_id_i,
  input  engine_types_pkg::addr_t   request_offset_i,
  input  engine_types_pkg::data_t   request_wdata_i,
  input  engine_types_pkg::strb_t   request_wstrb_i,
  output logic                      request_full_o,
  issue_if.decode                   issue
);

  // Queue entry is address, data, strobes, command and id
  localparam int ENTRY_W = engine_types_pkg::ADDR_W + engine_types_pkg::DATA_W
                         + engine_types_pkg::STRB_W + $bits(engine_cmd_pkg::cmd_t)
                         + engine_types_pkg::ID_W;

  engine_types_pkg::addr_t   desc_base_q;

  logic                      s1_valid;
  engine_cmd_pkg::cmd_t      s1_cmd;
  engine_types_pkg::req_id_t s1_id;
  engine_types_pkg::addr_t   s1_offset;
  engine_types_pkg::data_t   s1_wdata;
  engine_types_pkg::strb_t   s1_wstrb;

  logic                      s2_valid;
  engine_cmd_pkg::cmd_t      s2_cmd;
  engine_types_pkg::req_id_t s2_id;
  engine_types_pkg::addr_t   s2_addr;
  engine_types_pkg::data_t   s2_wdata;
  engine_types_pkg::strb_t   s2_wstrb;

  logic [ENTRY_W-1:0]        push_data;
  logic [ENTRY_W-1:0]        head_data;
  logic                      req_empty;

  // Base address, kept until a new descriptor arrives
  always_ff @(posedge ap_clk_i) begin
    if (desc_valid_i) begin
      desc_base_q <= desc_base_i;
    end
  end

  // --------------------------------------
  // Two-stage request registering
  // --------------------------------------
  always_ff @(posedge ap_clk_i) begin
    if (areset_control_i) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      s1_valid <= request_valid_i;
      s2_valid <= s1_valid;          // Push strobe for the queue
    end
  end

  always_ff @(posedge ap_clk_i) begin
    s1_cmd    <= request_cmd_i;
    s1_id     <= request_id_i;
    s1_offset <= request_offset_i;
    s1_wdata  <= request_wdata_i;
    s1_wstrb  <= request_wstrb_i;
    s2_cmd    <= s1_cmd;
    s2_id     <= s1_id;
    s2_addr   <= desc_base_q + s1_offset; // Address mapping
    s2_wdata  <= s1_wdata;
    s2_wstrb  <= s1_wstrb;
  end

  // --------------------------------------
  // Request queue
  // --------------------------------------
  assign push_data = {s2_addr, s2_wdata, s2_wstrb, s2_cmd, s2_id};

  // Threshold leaves room for both stages still in flight
  sync_fifo #(
    .WIDTH (ENTRY_W),
    .DEPTH (FIFO_DEPTH),
    .THRESH(FIFO_DEPTH - 3)
  ) u_request_fifo (
    .ap_clk_i        (ap_clk_i),
    .areset_control_i(areset_control_i),
    .wr_en_i         (s2_valid),
    .din_i           (push_data),
    .rd_en_i         (issue.pop),
    .dout_o          (head_data),
    .empty_o         (req_empty),
    .full_o          (),
    .prog_full_o     (request_full_o)
  );

  assign issue.valid = ~req_empty; // Head exists
  assign {issue.addr, issue.wdata, issue.wstrb, issue.cmd, issue.id} = head_data;

endmodule : request_decode

//--- logic/command_execute.sv
// Execute stage: gates issue, decodes read/write and drives the request/grant memory port
`timescale 1ns/1ps

module command_execute (
  input  logic                    ap_clk_i,
  input  logic                    areset_control_i,
  input  logic                    desc_valid_i,
  issue_if.execute                issue,
  meta_if.execute                 meta,
  input  logic                    resp_ready_i,
  output logic                    mem_req_o,
  output logic                    mem_we_o,
  output engine_types_pkg::addr_t mem_addr_o,
  output engine_types_pkg::data_t mem_wdata_o,
  output engine_types_pkg::strb_t mem_be_o,
  input  logic                    mem_gnt_i
);

  logic resp_ready_q; // Downstream allowance, one register deep
  logic desc_seen_q;  // Set by the first descriptor, cleared by reset
  logic req_hold_q;   // Request raised last cycle and not granted
  logic issue_ok;
  logic grant;

  // --------------------------------------
  // Control registers
  // --------------------------------------
  always_ff @(posedge ap_clk_i) begin
    if (areset_control_i) begin
      resp_ready_q <= 1'b0;
      desc_seen_q  <= 1'b0;
      req_hold_q   <= 1'b0;
    end else begin
      resp_ready_q <= resp_ready_i;
      if (desc_valid_i) begin
        desc_seen_q <= 1'b1;
      end
      req_hold_q <= mem_req_o & ~mem_gnt_i; // Keep asking until granted
    end
  end

  // --------------------------------------
  // Issue gating
  // --------------------------------------
  // New issues need a descriptor, downstream room and response queue space
  assign issue_ok = desc_seen_q & resp_ready_q & ~meta.prog_full;

  // A pending request stays up through back-pressure so the port holds stable
  assign mem_req_o = issue.valid & (req_hold_q | issue_ok);
  assign grant     = mem_req_o & mem_gnt_i;

  // --------------------------------------
  // Read/write decode
  // --------------------------------------
  assign mem_we_o    = engine_cmd_pkg::is_write(issue.cmd);
  assign mem_addr_o  = issue.addr;
  assign mem_wdata_o = issue.wdata;
  // Reads, stream reads and flushes carry no strobes
  assign mem_be_o    = issue.wstrb & {engine_types_pkg::STRB_W{mem_we_o}};

  // Head leaves the request queue and its identity enters the response queue together
  assign issue.pop = grant;
  assign meta.push = grant;
  assign meta.cmd  = issue.cmd;
  assign meta.id   = issue.id;

endmodule : command_execute

//--- logic/response_result.sv
// Response stage: tracks granted commands, pairs them with returned data and reports done
`timescale 1ns/1ps

module response_result #(
  parameter int FIFO_DEPTH  = 16,
  parameter int PROG_THRESH = 8
) (
  input  logic                      ap_clk_i,
  input  logic                      areset_control_i,
  meta_if.result                    meta,
  input  logic                      request_empty_i,
  input  logic                      mem_rsp_valid_i,
  input  engine_types_pkg::data_t   mem_rdata_i,
  output logic                      resp_valid_o,
  output engine_types_pkg::req_id_t resp_id_o,
  output engine_cmd_pkg::cmd_t      resp_cmd_o,
  output engine_types_pkg::data_t   resp_data_o,
  output logic                      done_o
);

  // Identity is command plus id
  localparam int META_W = $bits(engine_cmd_pkg::cmd_t) + engine_types_pkg::ID_W;

  logic [META_W-1:0]         meta_din;
  logic [META_W-1:0]         meta_dout;
  engine_cmd_pkg::cmd_t      head_cmd;
  engine_types_pkg::req_id_t head_id;
  logic                      both_empty;
  logic                      empty_q;    // First done stage

  // --------------------------------------
  // Response queue
  // --------------------------------------
  assign meta_din = {meta.cmd, meta.id};

  // Memory answers in grant order, so each response pops the oldest identity
  sync_fifo #(
    .WIDTH (META_W),
    .DEPTH (FIFO_DEPTH),
    .THRESH(PROG_THRESH)
  ) u_response_fifo (
    .ap_clk_i        (ap_clk_i),
    .areset_control_i(areset_control_i),
    .wr_en_i         (meta.push),
    .din_i           (meta_din),
    .rd_en_i         (mem_rsp_valid_i),
    .dout_o          (meta_dout),
    .empty_o         (meta.empty),
    .full_o          (),
    .prog_full_o     (meta.prog_full)
  );

  assign {head_cmd, head_id} = meta_dout;

  // --------------------------------------
  // Registered response
  // --------------------------------------
  always_ff @(posedge ap_clk_i) begin
    if (areset_control_i) begin
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= mem_rsp_valid_i; // One cycle behind the memory
    end
  end

  // Payload follows the valid bit, no reset
  always_ff @(posedge ap_clk_i) begin
    resp_id_o   <= head_id;
    resp_cmd_o  <= head_cmd;
    resp_data_o <= mem_rdata_i;
  end

  // --------------------------------------
  // Done
  // --------------------------------------
  assign both_empty = request_empty_i & meta.empty;

  // Two register stages between queue state and done_o
  always_ff @(posedge ap_clk_i) begin
    if (areset_control_i) begin
      empty_q <= 1'b0;
      done_o  <= 1'b0;
    end else begin
      empty_q <= both_empty;
      done_o  <= empty_q;
    end
  end

endmodule : response_result

//--- logic/mem_engine_top.sv
// Memory engine top level; sets queue parameters and connects decode, execute and response
`timescale 1ns/1ps

module mem_engine_top #(
  parameter int FIFO_DEPTH  = 16, // Depth of both queues, power of two
  parameter int PROG_THRESH = 8   // Response fill level that blocks issue
) (
  input  logic                      ap_clk_i,
  input  logic                      areset_control_i,
  // Descriptor
  input  logic                      desc_valid_i,
  input  engine_types_pkg::addr_t   desc_base_i,
  // Request stream
  input  logic                      request_valid_i,
  input  engine_cmd_pkg::cmd_t      request_cmd_i,
  input  engine_types_pkg::req_id_t request_id_i,
  input  engine_types_pkg::addr_t   request_offset_i,
  input  engine_types_pkg::data_t   request_wdata_i,
  input  engine_types_pkg::strb_t   request_wstrb_i,
  output logic                      request_full_o,
  // Memory port
  output logic                      mem_req_o,
  output logic                      mem_we_o,
  output engine_types_pkg::addr_t   mem_addr_o,
  output engine_types_pkg::data_t   mem_wdata_o,
  output engine_types_pkg::strb_t   mem_be_o,
  input  logic                      mem_gnt_i,
  input  logic                      mem_rsp_valid_i,
  input  engine_types_pkg::data_t   mem_rdata_i,
  // Response stream
  input  logic                      resp_ready_i,
  output logic                      resp_valid_o,
  output engine_types_pkg::req_id_t resp_id_o,
  output engine_cmd_pkg::cmd_t      resp_cmd_o,
  output engine_types_pkg::data_t   resp_data_o,
  // Status
  output logic                      done_o
);

  issue_if issue_bus (); // Request queue head
  meta_if  meta_bus ();  // Granted command identities

  request_decode #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_request_decode (
    .ap_clk_i        (ap_clk_i),
    .areset_control_i(areset_control_i),
    .desc_valid_i    (desc_valid_i),
    .desc_base_i     (desc_base_i),
    .request_valid_i (request_valid_i),
    .request_cmd_i   (request_cmd_i),
    .request_id_i    (request_id_i),
    .request_offset_i(request_offset_i),
    .request_wdata_i (request_wdata_i),
    .request_wstrb_i (request_wstrb_i),
    .request_full_o  (request_full_o),
    .issue           (issue_bus.decode)
  );

  command_execute u_command_execute (
    .ap_clk_i        (ap_clk_i),
    .areset_control_i(areset_control_i),
    .desc_valid_i    (desc_valid_i),
    .issue           (issue_bus.execute),
    .meta            (meta_bus.execute),
    .resp_ready_i    (resp_ready_i),
    .mem_req_o       (mem_req_o),
    .mem_we_o        (mem_we_o),
    .mem_addr_o      (mem_addr_o),
    .mem_wdata_o     (mem_wdata_o),
    .mem_be_o        (mem_be_o),
    .mem_gnt_i       (mem_gnt_i)
  );

  response_result #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .PROG_THRESH(PROG_THRESH)
  ) u_response_result (
    .ap_clk_i        (ap_clk_i),
    .areset_control_i(areset_control_i),
    .meta            (meta_bus.result),
    .request_empty_i (~issue_bus.valid), // No head means request queue empty
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rdata_i     (mem_rdata_i),
    .resp_valid_o    (resp_valid_o),
    .resp_id_o       (resp_id_o),
    .resp_cmd_o      (resp_cmd_o),
    .resp_data_o     (resp_data_o),
    .done_o          (done_o)
  );

endmodule : mem_engine_top

//--- test/mem_engine_sva.sv
// Port-rule assertions for the memory engine, bound into every mem_engine_top instance
`timescale 1ns/1ps

module mem_engine_sva (
  input logic                    ap_clk_i,
  input logic                    areset_control_i,
  input logic                    mem_req_o,
  input logic                    mem_we_o,
  input engine_types_pkg::addr_t mem_addr_o,
  input engine_types_pkg::data_t mem_wdata_o,
  input engine_types_pkg::strb_t mem_be_o,
  input logic                    mem_gnt_i,
  input logic                    mem_rsp_valid_i,
  input logic                    resp_valid_o
);

  // --------------------------------------
  // Memory port rules
  // --------------------------------------
  // Stalled request holds its fields until granted
  a_req_stable: assert property (@(posedge ap_clk_i) disable iff (areset_control_i)
    mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_we_o) && $stable(mem_addr_o)
                                && $stable(mem_wdata_o) && $stable(mem_be_o))
    else $error("memory request changed while waiting for grant");

  a_read_no_strobe: assert property (@(posedge ap_clk_i) disable iff (areset_control_i)
    !mem_we_o |-> mem_be_o == '0)
    else $error("strobes set on a non-write command");

  // Response register is one cycle deep
  a_resp_follows: assert property (@(posedge ap_clk_i) disable iff (areset_control_i)
    1'b1 |=> resp_valid_o == $past(mem_rsp_valid_i))
    else $error("resp_valid_o does not follow mem_rsp_valid_i by one cycle");

endmodule : mem_engine_sva

bind mem_engine_top mem_engine_sva u_port_checks (.*);

//--- test/mem_engine_tb.sv
// Directed testbench for the memory engine top level with an in-order memory model and watchdog
`timescale 1ns/1ps

module mem_engine_tb;

  localparam int FIFO_DEPTH  = 16;
  localparam int PROG_THRESH = 8;
  localparam int N_CMDS      = 31;                           // Commands sent over all tests
  localparam engine_types_pkg::data_t RD_KEY = 32'hA5A5_0000; // Read data is address XOR this

  typedef struct packed {
    logic                    we;
    engine_types_pkg::addr_t addr;
    engine_types_pkg::data_t data;
    engine_types_pkg::strb_t be;
  } port_exp_t;

  typedef struct packed {
    engine_types_pkg::req_id_t id;
    engine_cmd_pkg::cmd_t      cmd;
    engine_types_pkg::data_t   data;
  } rsp_exp_t;

  logic                      ap_clk_i;
  logic                      areset_control_i;
  logic                      desc_valid_i;
  engine_types_pkg::addr_t   desc_base_i;
  logic                      request_valid_i;
  engine_cmd_pkg::cmd_t      request_cmd_i;
  engine_types_pkg::req_id_t request_id_i;
  engine_types_pkg::addr_t   request_offset_i;
  engine_types_pkg::data_t   request_wdata_i;
  engine_types_pkg::strb_t   request_wstrb_i;
  logic                      request_full_o;
  logic                      mem_req_o;
  logic                      mem_we_o;
  engine_types_pkg::addr_t   mem_addr_o;
  engine_types_pkg::data_t   mem_wdata_o;
  engine_types_pkg::strb_t   mem_be_o;
  logic                      mem_gnt_i;
  logic                      mem_rsp_valid_i;
  engine_types_pkg::data_t   mem_rdata_i;
  logic                      resp_ready_i;
  logic                      resp_valid_o;
  engine_types_pkg::req_id_t resp_id_o;
  engine_cmd_pkg::cmd_t      resp_cmd_o;
  engine_types_pkg::data_t   resp_data_o;
  logic                      done_o;

  port_exp_t                 port_q [$];   // Expected memory commands, issue order
  rsp_exp_t                  rsp_q [$];    // Expected responses, same order
  engine_types_pkg::data_t   wmem [engine_types_pkg::addr_t]; // Recorded writes
  engine_types_pkg::data_t   pipe_d [3];   // Memory latency pipeline
  logic [2:0]                pipe_v;
  engine_types_pkg::addr_t   cur_base;
  logic [31:0]               lfsr;
  logic                      rr_model;     // Mirror of the registered resp_ready_i
  logic                      prev_hold;    // Request was up and not granted last cycle
  logic                      desc_given;
  int                        mismatch_errs;
  int                        other_errs;

  mem_engine_top #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .PROG_THRESH(PROG_THRESH)
  ) UUT (.*);

  initial begin : clock_gen
    ap_clk_i = 1'b0;
    forever #5 ap_clk_i = ~ap_clk_i; // 10 ns period
  end

  // Galois LFSR stepped once per random bit
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic flag_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    mismatch_errs++;
    $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, want);
  endtask

  task automatic count_failure(input string what);
    other_errs++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  task automatic finish_run();
    $display("Errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
    if (mismatch_errs == 0 && other_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  // --------------------------------------
  // Memory model and response checker
  // --------------------------------------
  always @(posedge ap_clk_i) begin
    rr_model <= resp_ready_i; // Same sampling as the DUT register
  end

  always @(negedge ap_clk_i) begin : mem_model
    port_exp_t pexp;
    rsp_exp_t  rexp;
    mem_rsp_valid_i = pipe_v[2];            // Answer three cycles after the grant
    mem_rdata_i     = pipe_d[2];
    pipe_v          = {pipe_v[1:0], 1'b0};
    pipe_d[2]       = pipe_d[1];
    pipe_d[1]       = pipe_d[0];
    if (mem_req_o === 1'b1 && !desc_given) count_failure("mem_req_o high before any descriptor");
    if (mem_req_o === 1'b1 && !prev_hold && !rr_model) begin
      count_failure("new mem_req_o issued while registered resp_ready_i was low");
    end
    lfsr      = lfsr_next(lfsr);
    mem_gnt_i = lfsr[0];                    // Random grant back-pressure
    if (mem_req_o === 1'b1 && mem_gnt_i) begin
      if (port_q.size() == 0) begin
        count_failure("memory command granted with none expected");
      end else begin
        pexp = port_q.pop_front();
        if (mem_we_o !== pexp.we) flag_mismatch("mem_we_o", mem_we_o, pexp.we);
        if (mem_addr_o !== pexp.addr) flag_mismatch("mem_addr_o", mem_addr_o, pexp.addr);
        if (mem_be_o !== pexp.be) flag_mismatch("mem_be_o", mem_be_o, pexp.be);
        if (pexp.we && mem_wdata_o !== pexp.data) begin
          flag_mismatch("mem_wdata_o", mem_wdata_o, pexp.data);
        end
      end
      if (mem_we_o) begin
        wmem[mem_addr_o] = mem_wdata_o & {{8{mem_be_o[3]}}, {8{mem_be_o[2]}},
                                          {8{mem_be_o[1]}}, {8{mem_be_o[0]}}};
      end
      pipe_v[0] = 1'b1;
      pipe_d[0] = mem_addr_o ^ RD_KEY;
    end
    prev_hold = (mem_req_o === 1'b1) && !mem_gnt_i;
    if (resp_valid_o === 1'b1) begin
      if (rsp_q.size() == 0) begin
        count_failure("response with no command outstanding");
      end else begin
        rexp = rsp_q.pop_front();             // In order with none lost or doubled
        if (resp_id_o !== rexp.id) flag_mismatch("resp_id_o", resp_id_o, rexp.id);
        if (resp_cmd_o !== rexp.cmd) flag_mismatch("resp_cmd_o", resp_cmd_o, rexp.cmd);
        if (resp_data_o !== rexp.data) flag_mismatch("resp_data_o", resp_data_o, rexp.data);
      end
    end
  end

  // --------------------------------------
  // Stimulus tasks
  // --------------------------------------
  task automatic apply_reset();
    @(negedge ap_clk_i);
    areset_control_i = 1'b1;
    desc_given       = 1'b0;
    repeat (5) @(negedge ap_clk_i);
    areset_control_i = 1'b0;
  endtask

  task automatic give_descriptor(input engine_types_pkg::addr_t base);
    @(negedge ap_clk_i);
    desc_valid_i = 1'b1;
    desc_base_i  = base;
    cur_base     = base;
    desc_given   = 1'b1;
    @(negedge ap_clk_i);
    desc_valid_i = 1'b0;
  endtask

  // Leaves request_valid_i high until the next call or drain() drops it
  task automatic send_cmd(input engine_cmd_pkg::cmd_t cmd, input engine_types_pkg::req_id_t id,
                          input engine_types_pkg::addr_t offset,
                          input engine_types_pkg::data_t wdata,
                          input engine_types_pkg::strb_t wstrb);
    logic we;
    @(negedge ap_clk_i);
    while (request_full_o) begin
      request_valid_i = 1'b0;
      @(negedge ap_clk_i);
    end
    request_valid_i  = 1'b1;
    request_cmd_i    = cmd;
    request_id_i     = id;
    request_offset_i = offset;
    request_wdata_i  = wdata;
    request_wstrb_i  = wstrb;
    // Only the two write codes write and carry strobes
    we = (cmd == engine_cmd_pkg::CMD_MEM_WRITE) || (cmd == engine_cmd_pkg::CMD_STREAM_WRITE);
    if (desc_given) begin
      port_q.push_back('{we, cur_base + offset, wdata, we ? wstrb : 4'h0});
      rsp_q.push_back('{id, cmd, (cur_base + offset) ^ RD_KEY});
    end
  endtask

  task automatic drain();
    @(negedge ap_clk_i);
    request_valid_i = 1'b0;
    while (rsp_q.size() != 0) @(negedge ap_clk_i);
    if (port_q.size() != 0) count_failure("commands still unissued after drain");
    repeat (2) @(negedge ap_clk_i);         // done_o trails the empty queues by two cycles
    if (done_o !== 1'b1) flag_mismatch("done_o", done_o, 1'b1);
  endtask

  // --------------------------------------
  // Directed tests
  // --------------------------------------
  task automatic idle_after_reset();
    if (mem_req_o !== 1'b0) flag_mismatch("mem_req_o", mem_req_o, 1'b0);
    if (resp_valid_o !== 1'b0) flag_mismatch("resp_valid_o", resp_valid_o, 1'b0);
    if (done_o !== 1'b0) flag_mismatch("done_o", done_o, 1'b0);
    if (request_full_o !== 1'b0) flag_mismatch("request_full_o", request_full_o, 1'b0);
    send_cmd(engine_cmd_pkg::CMD_MEM_READ, 8'h01, 32'h40, 32'h0, 4'h0);
    @(negedge ap_clk_i);
    request_valid_i = 1'b0;
    repeat (12) @(negedge ap_clk_i);        // Model flags any request here
    apply_reset();                          // Flush the stranded request
  endtask

  task automatic read_commands();
    give_descriptor(32'h1000_0000);
    send_cmd(engine_cmd_pkg::CMD_MEM_READ, 8'h10, 32'h0040, 32'hFFFF_FFFF, 4'hF);
    send_cmd(engine_cmd_pkg::CMD_STREAM_READ, 8'h11, 32'h0104, 32'h1234_5678, 4'hF);
    send_cmd(engine_cmd_pkg::CMD_CACHE_FLUSH, 8'h12, 32'h0800, 32'h0, 4'h3);
    drain();
  endtask

  task automatic write_commands();
    send_cmd(engine_cmd_pkg::CMD_MEM_WRITE, 8'h20, 32'h0010, 32'hDEAD_BEEF, 4'b0011);
    send_cmd(engine_cmd_pkg::CMD_STREAM_WRITE, 8'h21, 32'h0020, 32'hCAFE_F00D, 4'hF);
    drain();
    if (wmem[32'h1000_0010] !== 32'h0000_BEEF) begin
      flag_mismatch("write at 10000010", wmem[32'h1000_0010], 32'h0000_BEEF);
    end
    if (wmem[32'h1000_0020] !== 32'hCAFE_F00D) begin
      flag_mismatch("write at 10000020", wmem[32'h1000_0020], 32'hCAFE_F00D);
    end
  endtask

  task automatic ordered_under_stall();
    fork
      begin
        for (int i = 0; i < 24; i++) begin
          send_cmd(engine_cmd_pkg::cmd_t'(i % 5 + 1), 8'h40 + i, 32'h0200 + i * 4,
                   32'h5000_0000 + i, 4'(i));
        end
      end
      begin
        repeat (15) @(negedge ap_clk_i);
        resp_ready_i = 1'b0;                // Downstream stall
        repeat (40) @(negedge ap_clk_i);
        resp_ready_i = 1'b1;
      end
    join
    drain();
  endtask

  task automatic done_while_pending();
    send_cmd(engine_cmd_pkg::CMD_MEM_READ, 8'h60, 32'h0300, 32'h0, 4'h0);
    @(negedge ap_clk_i);
    request_valid_i = 1'b0;
    repeat (4) @(negedge ap_clk_i);
    if (done_o !== 1'b0) count_failure("done_o high while a command is pending");
    drain();
  endtask

  initial begin : watchdog
    repeat (200 * N_CMDS + 1000) @(posedge ap_clk_i);
    count_failure("watchdog expired before the tests finished");
    finish_run();
  end

  initial begin : main
    areset_control_i = 1'b1;
    desc_valid_i     = 1'b0;
    desc_base_i      = '0;
    request_valid_i  = 1'b0;
    request_cmd_i    = '0;
    request_id_i     = '0;
    request_offset_i = '0;
    request_wdata_i  = '0;
    request_wstrb_i  = '0;
    mem_gnt_i        = 1'b0;
    mem_rsp_valid_i  = 1'b0;
    mem_rdata_i      = '0;
    resp_ready_i     = 1'b1;
    lfsr             = 32'h6e96;
    pipe_v           = '0;
    prev_hold        = 1'b0;
    desc_given       = 1'b0;
    cur_base         = '0;
    mismatch_errs    = 0;
    other_errs       = 0;
    apply_reset();
    idle_after_reset();
    read_commands();
    write_commands();
    ordered_under_stall();
    done_while_pending();
    finish_run();
  end

endmodule : mem_engine_tb

//--- sim.f
logic/engine_types_pkg.sv
logic/engine_cmd_pkg.sv
logic/engine_if.sv
logic/sync_fifo.sv
logic/request_decode.sv
logic/command_execute.sv
logic/response_result.sv
logic/mem_engine_top.sv
test/mem_engine_sva.sv
test/mem_engine_tb.sv

//--- Bender.yml
package:
  name: mem_engine

sources:
  - logic/engine_types_pkg.sv
  - logic/engine_cmd_pkg.sv
  - logic/engine_if.sv
  - logic/sync_fifo.sv
  - logic/request_decode.sv
  - logic/command_execute.sv
  - logic/response_result.sv
  - logic/mem_engine_top.sv
  - target: test
    files:
      - test/mem_engine_sva.sv
      - test/mem_engine_tb.sv
